// ==== src/boardtime_pkg.sv ====
package boardtime_pkg;

	// sample clock timestamp width
	localparam int STAMP_W = 64;

	// mixer coefficient bank
	localparam int COEF_N = 64;
	localparam int COEF_W = 32;
	localparam int COEF_AW = $clog2(COEF_N);

	// sysref rising edges before the timebase runs
	localparam int SYSREF_EDGES = 4;
	localparam int EDGE_W = $clog2(SYSREF_EDGES + 1);
	localparam logic [EDGE_W-1:0] EDGE_DONE = EDGE_W'(SYSREF_EDGES);

	// dsp reset stretch in dspclk cycles
	localparam int RESET_HOLD = 4;
	localparam int HOLD_W = $clog2(RESET_HOLD);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(RESET_HOLD - 1);

	// tx start bit to rx stamp, zero delay loop
	localparam int LINK_LAT = 3;
	localparam int LINK_CW = $clog2(STAMP_W + 1);
	localparam logic [LINK_CW-1:0] LINK_BITS = LINK_CW'(STAMP_W);

	// register word addresses
	localparam logic [7:0] REG_CTRL = 8'd0;
	localparam logic [7:0] REG_STATUS = 8'd1;
	localparam logic [7:0] REG_CORR_L = 8'd2;
	localparam logic [7:0] REG_CORR_H = 8'd3;
	localparam logic [7:0] REG_TRIG_L = 8'd4;
	localparam logic [7:0] REG_TRIG_H = 8'd5;
	localparam logic [7:0] REG_CNT_L = 8'd6;
	localparam logic [7:0] REG_CNT_H = 8'd7;
	localparam logic [7:0] REG_LINK_GO = 8'd8;
	localparam logic [7:0] REG_TXST_L = 8'd9;
	localparam logic [7:0] REG_TXST_H = 8'd10;
	localparam logic [7:0] REG_RXST_L = 8'd11;
	localparam logic [7:0] REG_RXST_H = 8'd12;
	localparam logic [7:0] REG_RXPL_L = 8'd13;
	localparam logic [7:0] REG_RXPL_H = 8'd14;
	// coefficient window, one word per coefficient
	localparam logic [7:0] REG_COEF_BASE = 8'd64;

	// wishbone classic, word addressed
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [7:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic arm;
		logic corr_sel;
		logic [STAMP_W-1:0] corr;
		logic [STAMP_W-1:0] trig;
	} time_cfg_t;

	// tx_go is a single cycle send request
	typedef struct packed {
		logic tx_en;
		logic tx_go;
	} link_cfg_t;

	typedef struct packed {
		logic rx_valid;
		logic [STAMP_W-1:0] tx_stamp;
		logic [STAMP_W-1:0] rx_stamp;
		logic [STAMP_W-1:0] rx_payload;
	} link_stat_t;

	typedef struct packed {
		logic we;
		logic [COEF_AW-1:0] addr;
		logic [COEF_W-1:0] data;
	} coef_wr_t;

endpackage

// ==== src/wb_cfg_regs.sv ====
`timescale 1ns/100ps

module wb_cfg_regs (
	input  logic dspclk,
	input  logic rst,
	input  boardtime_pkg::wb_req_t wb_req,
	output boardtime_pkg::wb_rsp_t wb_rsp,
	output boardtime_pkg::time_cfg_t time_cfg,
	output boardtime_pkg::link_cfg_t link_cfg,
	output boardtime_pkg::coef_wr_t coef_wr,
	output logic [boardtime_pkg::COEF_AW-1:0] coef_rd_addr,
	input  logic [boardtime_pkg::COEF_W-1:0] coef_rd_data,
	input  logic [boardtime_pkg::STAMP_W-1:0] count,
	input  logic ready,
	input  logic start,
	input  boardtime_pkg::link_stat_t link_stat,
	output logic dsp_reset
);
	logic ack_r;
	logic acc;
	logic wr;
	logic rd;
	logic in_win;
	logic coef_sel_r;
	logic dsp_strobe;
	logic [31:0] rd_mux;
	logic [31:0] rd_dat_r;
	logic [31:0] cnt_hi_snap;
	logic [boardtime_pkg::HOLD_W-1:0] hold_cnt;

	// new access only when ack was low last cycle
	assign acc = wb_req.cyc && wb_req.stb && !ack_r;
	assign wr = acc && wb_req.we;
	assign rd = acc && !wb_req.we;
	// 64 word coefficient window
	assign in_win = (wb_req.adr >= boardtime_pkg::REG_COEF_BASE)
		&& (wb_req.adr < boardtime_pkg::REG_COEF_BASE + boardtime_pkg::COEF_N);
	// ctrl bit 3 strobes the dsp reset
	assign dsp_strobe = wr && (wb_req.adr == boardtime_pkg::REG_CTRL) && wb_req.dat[3];

	// coef write lands on the ack edge
	assign coef_wr = '{
		we: wr && in_win,
		addr: wb_req.adr[boardtime_pkg::COEF_AW-1:0],
		data: wb_req.dat
	};
	// bank read is registered, valid during ack
	assign coef_rd_addr = wb_req.adr[boardtime_pkg::COEF_AW-1:0];

	assign wb_rsp = '{ack: ack_r, dat: coef_sel_r ? coef_rd_data : rd_dat_r};

	// readback select
	always_comb begin
		rd_mux = '0;
		case (wb_req.adr)
			boardtime_pkg::REG_CTRL: begin
				rd_mux[2:0] = {link_cfg.tx_en, time_cfg.corr_sel, time_cfg.arm};
			end
			boardtime_pkg::REG_STATUS: begin
				rd_mux[2:0] = {link_stat.rx_valid, start, ready};
			end
			boardtime_pkg::REG_CORR_L: rd_mux = time_cfg.corr[31:0];
			boardtime_pkg::REG_CORR_H: rd_mux = time_cfg.corr[63:32];
			boardtime_pkg::REG_TRIG_L: rd_mux = time_cfg.trig[31:0];
			boardtime_pkg::REG_TRIG_H: rd_mux = time_cfg.trig[63:32];
			boardtime_pkg::REG_CNT_L: rd_mux = count[31:0];
			// high half from the snapshot taken with the low read
			boardtime_pkg::REG_CNT_H: rd_mux = cnt_hi_snap;
			boardtime_pkg::REG_TXST_L: rd_mux = link_stat.tx_stamp[31:0];
			boardtime_pkg::REG_TXST_H: rd_mux = link_stat.tx_stamp[63:32];
			boardtime_pkg::REG_RXST_L: rd_mux = link_stat.rx_stamp[31:0];
			boardtime_pkg::REG_RXST_H: rd_mux = link_stat.rx_stamp[63:32];
			boardtime_pkg::REG_RXPL_L: rd_mux = link_stat.rx_payload[31:0];
			boardtime_pkg::REG_RXPL_H: rd_mux = link_stat.rx_payload[63:32];
			default: rd_mux = '0;
		endcase
	end

	// ack, config registers and the send pulse
	always_ff @(posedge dspclk) begin
		if (rst) begin
			ack_r <= 1'b0;
			coef_sel_r <= 1'b0;
			time_cfg <= '0;
			link_cfg <= '0;
		end else begin
			ack_r <= acc;
			coef_sel_r <= rd && in_win;
			link_cfg.tx_go <= wr && (wb_req.adr == boardtime_pkg::REG_LINK_GO);
			if (wr) begin
				case (wb_req.adr)
					boardtime_pkg::REG_CTRL: begin
						time_cfg.arm <= wb_req.dat[0];
						time_cfg.corr_sel <= wb_req.dat[1];
						link_cfg.tx_en <= wb_req.dat[2];
					end
					boardtime_pkg::REG_CORR_L: time_cfg.corr[31:0] <= wb_req.dat;
					boardtime_pkg::REG_CORR_H: time_cfg.corr[63:32] <= wb_req.dat;
					boardtime_pkg::REG_TRIG_L: time_cfg.trig[31:0] <= wb_req.dat;
					boardtime_pkg::REG_TRIG_H: time_cfg.trig[63:32] <= wb_req.dat;
					default: ;
				endcase
			end
		end
	end

	// read data and count snapshot
	always_ff @(posedge dspclk) begin
		if (rd) begin
			rd_dat_r <= rd_mux;
		end
		if (rd && (wb_req.adr == boardtime_pkg::REG_CNT_L)) begin
			cnt_hi_snap <= count[63:32];
		end
	end

	// dsp reset stretcher
	// high from the strobe edge for RESET_HOLD cycles
	always_ff @(posedge dspclk) begin
		if (rst) begin
			hold_cnt <= '0;
			dsp_reset <= 1'b1;
		end else if (dsp_strobe) begin
			hold_cnt <= boardtime_pkg::HOLD_LAST;
			dsp_reset <= 1'b1;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end else begin
			dsp_reset <= 1'b0;
		end
	end

endmodule

// ==== src/sysref_timebase.sv ====
`timescale 1ns/100ps

module sysref_timebase (
	input  logic dspclk,
	input  logic rst,
	input  logic sysref,
	input  boardtime_pkg::time_cfg_t time_cfg,
	output logic [boardtime_pkg::STAMP_W-1:0] count,
	output logic ready,
	output logic start
);
	logic [1:0] sysref_s;
	logic sysref_rise;
	logic [boardtime_pkg::EDGE_W-1:0] edge_cnt;
	logic [boardtime_pkg::STAMP_W-1:0] raw_cnt;
	logic [boardtime_pkg::STAMP_W-1:0] corr_cnt;

	// sysref sampled twice
	// edge taken between the two flops
	assign sysref_rise = sysref_s[0] && !sysref_s[1];

	always_ff @(posedge dspclk) begin
		if (rst) begin
			sysref_s <= '0;
			edge_cnt <= '0;
			ready <= 1'b0;
		end else begin
			sysref_s <= {sysref_s[0], sysref};
			// count edges only while armed
			// saturates at the ready threshold
			if (time_cfg.arm && sysref_rise && (edge_cnt != boardtime_pkg::EDGE_DONE)) begin
				edge_cnt <= edge_cnt + 1'b1;
			end
			// sticky until reset
			if (edge_cnt == boardtime_pkg::EDGE_DONE) begin
				ready <= 1'b1;
			end
		end
	end

	// free running sample counter once ready
	always_ff @(posedge dspclk) begin
		if (rst) begin
			raw_cnt <= '0;
		end else if (ready) begin
			raw_cnt <= raw_cnt + 1'b1;
		end
	end

	// corrected count lags raw by one cycle
	always_ff @(posedge dspclk) begin
		corr_cnt <= raw_cnt + time_cfg.corr;
	end

	assign count = time_cfg.corr_sel ? corr_cnt : raw_cnt;

	// start compare
	// held off until the timebase is ready
	always_ff @(posedge dspclk) begin
		if (rst) begin
			start <= 1'b0;
		end else begin
			start <= ready && (count >= time_cfg.trig);
		end
	end

endmodule

// ==== src/coef_bank.sv ====
`timescale 1ns/100ps

module coef_bank (
	input  logic dspclk,
	input  logic rst,
	input  boardtime_pkg::coef_wr_t coef_wr,
	input  logic [boardtime_pkg::COEF_AW-1:0] rd_addr,
	output logic [boardtime_pkg::COEF_W-1:0] rd_data,
	output logic [boardtime_pkg::COEF_N-1:0][boardtime_pkg::COEF_W-1:0] coef
);
	// word storage doubles as the flat mixer output
	// all words visible to the dsp at once
	always_ff @(posedge dspclk) begin
		if (rst) begin
			coef <= '0;
		end else if (coef_wr.we) begin
			// one word per write strobe
			coef[coef_wr.addr] <= coef_wr.data;
		end
	end

	// registered readback
	// address to data in one cycle
	always_ff @(posedge dspclk) begin
		rd_data <= coef[rd_addr];
	end

endmodule

// ==== src/stamp_link.sv ====
`timescale 1ns/100ps

module stamp_link (
	input  logic dspclk,
	input  logic rst,
	input  boardtime_pkg::link_cfg_t link_cfg,
	input  logic [boardtime_pkg::STAMP_W-1:0] count,
	output logic sync_tx,
	output logic sync_en,
	input  logic sync_rx,
	output boardtime_pkg::link_stat_t link_stat
);
	logic tx_start;
	logic [boardtime_pkg::LINK_CW-1:0] tx_cnt;
	logic [boardtime_pkg::STAMP_W-1:0] tx_sh;
	logic [boardtime_pkg::STAMP_W-1:0] tx_stamp;
	logic [1:0] rx_s;
	logic [boardtime_pkg::LINK_CW-1:0] rx_cnt;
	logic [boardtime_pkg::STAMP_W-1:0] rx_sh;
	logic [boardtime_pkg::STAMP_W-1:0] rx_stamp;
	logic [boardtime_pkg::STAMP_W-1:0] rx_payload;
	logic rx_valid;

	// go is dropped mid frame or with tx disabled
	assign tx_start = (tx_cnt == '0) && link_cfg.tx_go && link_cfg.tx_en;

	// transmitter
	// tx_cnt holds payload bits still to send
	always_ff @(posedge dspclk) begin
		if (rst) begin
			tx_cnt <= '0;
			sync_tx <= 1'b0;
			sync_en <= 1'b0;
		end else begin
			sync_en <= link_cfg.tx_en;
			if (tx_cnt != '0) begin
				sync_tx <= tx_sh[boardtime_pkg::STAMP_W-1];
				tx_cnt <= tx_cnt - 1'b1;
			end else if (tx_start) begin
				sync_tx <= 1'b1;
				tx_cnt <= boardtime_pkg::LINK_BITS;
			end else begin
				sync_tx <= 1'b0;
			end
		end
	end

	// msb first shift
	// stamp taken with the start bit
	always_ff @(posedge dspclk) begin
		if (tx_cnt != '0) begin
			tx_sh <= {tx_sh[boardtime_pkg::STAMP_W-2:0], 1'b0};
		end else if (tx_start) begin
			tx_sh <= count;
			tx_stamp <= count;
		end
	end

	// receiver control
	// start bit seen on the second sync flop
	always_ff @(posedge dspclk) begin
		if (rst) begin
			rx_s <= '0;
			rx_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_s <= {rx_s[0], sync_rx};
			if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
				if (rx_cnt == 1'b1) begin
					rx_valid <= 1'b1;
				end
			end else if (rx_s[1]) begin
				rx_cnt <= boardtime_pkg::LINK_BITS;
				rx_valid <= 1'b0;
			end
		end
	end

	// receive shift and captures
	always_ff @(posedge dspclk) begin
		if (rx_cnt != '0) begin
			rx_sh <= {rx_sh[boardtime_pkg::STAMP_W-2:0], rx_s[1]};
			// last bit completes the payload
			if (rx_cnt == 1'b1) begin
				rx_payload <= {rx_sh[boardtime_pkg::STAMP_W-2:0], rx_s[1]};
			end
		end else if (rx_s[1]) begin
			rx_stamp <= count;
		end
	end

	assign link_stat = '{
		rx_valid: rx_valid,
		tx_stamp: tx_stamp,
		rx_stamp: rx_stamp,
		rx_payload: rx_payload
	};

endmodule

// ==== src/boardtime_top.sv ====
`timescale 1ns/100ps

module boardtime_top (
	input  logic dspclk,
	input  logic rst,
	input  boardtime_pkg::wb_req_t wb_req,
	output boardtime_pkg::wb_rsp_t wb_rsp,
	input  logic sysref,
	input  logic sync_rx,
	output logic sync_tx,
	output logic sync_en,
	output logic start,
	output logic dsp_reset,
	output logic [boardtime_pkg::COEF_N-1:0][boardtime_pkg::COEF_W-1:0] coef
);
	boardtime_pkg::time_cfg_t time_cfg;
	boardtime_pkg::link_cfg_t link_cfg;
	boardtime_pkg::link_stat_t link_stat;
	boardtime_pkg::coef_wr_t coef_wr;
	logic [boardtime_pkg::COEF_AW-1:0] coef_rd_addr;
	logic [boardtime_pkg::COEF_W-1:0] coef_rd_data;
	// selected count, shared by readback and link stamps
	logic [boardtime_pkg::STAMP_W-1:0] count;
	logic ready;

	// register slave and reset stretcher
	wb_cfg_regs wb_cfg_regs_i (
		.dspclk(dspclk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.time_cfg(time_cfg),
		.link_cfg(link_cfg),
		.coef_wr(coef_wr),
		.coef_rd_addr(coef_rd_addr),
		.coef_rd_data(coef_rd_data),
		.count(count),
		.ready(ready),
		.start(start),
		.link_stat(link_stat),
		.dsp_reset(dsp_reset)
	);

	sysref_timebase sysref_timebase_i (
		.dspclk(dspclk),
		.rst(rst),
		.sysref(sysref),
		.time_cfg(time_cfg),
		.count(count),
		.ready(ready),
		.start(start)
	);

	// timestamp link
	stamp_link stamp_link_i (
		.dspclk(dspclk),
		.rst(rst),
		.link_cfg(link_cfg),
		.count(count),
		.sync_tx(sync_tx),
		.sync_en(sync_en),
		.sync_rx(sync_rx),
		.link_stat(link_stat)
	);

	coef_bank coef_bank_i (
		.dspclk(dspclk),
		.rst(rst),
		.coef_wr(coef_wr),
		.rd_addr(coef_rd_addr),
		.rd_data(coef_rd_data),
		.coef(coef)
	);

endmodule

// ==== tests/boardtime_chk.sv ====
`timescale 1ns/100ps

module boardtime_chk (
	input logic dspclk,
	input logic rst,
	input boardtime_pkg::wb_req_t wb_req,
	input boardtime_pkg::wb_rsp_t wb_rsp,
	input logic ready,
	input logic start,
	input logic sync_tx
);
	// single cycle ack
	ack_one_cycle: assert property (@(posedge dspclk) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("wishbone ack held for two cycles");

	// ack only answers a strobe
	ack_after_strobe: assert property (@(posedge dspclk) disable iff (rst)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
		else $error("wishbone ack without cyc and stb");

	// no start before the timebase runs
	start_needs_ready: assert property (@(posedge dspclk) disable iff (rst)
		!ready |-> !start)
		else $error("start high while ready is low");

	// line idles low out of reset
	tx_idle_after_reset: assert property (@(posedge dspclk)
		$past(rst) |-> !sync_tx)
		else $error("sync_tx high right after reset");

endmodule

// ==== tests/boardtime_tb.sv ====
`timescale 1ns/100ps

module boardtime_tb;
	// rough access count of the sequence below
	localparam int ACCESS_COUNT = 360;
	localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 4 + 2000;
	localparam int ACK_WAIT = 16;
	localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

	logic dspclk;
	logic rst;
	logic sysref;
	logic sync_rx;
	logic sync_tx;
	logic sync_en;
	logic start;
	logic dsp_reset;
	boardtime_pkg::wb_req_t wb_req;
	boardtime_pkg::wb_rsp_t wb_rsp;
	logic [boardtime_pkg::COEF_N-1:0][boardtime_pkg::COEF_W-1:0] coef;

	logic [31:0] lfsr_state;
	int mismatch_count;
	int other_errors;

	// register model
	logic [2:0] ctrl_m;
	logic [63:0] corr_m;
	logic [63:0] trig_m;
	logic [31:0] coef_m [boardtime_pkg::COEF_N];

	// pending compares
	logic [63:0] got_q [$];
	logic [63:0] exp_q [$];
	string name_q [$];

	boardtime_top boardtime_top_i (
		.dspclk(dspclk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.sysref(sysref),
		.sync_rx(sync_rx),
		.sync_tx(sync_tx),
		.sync_en(sync_en),
		.start(start),
		.dsp_reset(dsp_reset),
		.coef(coef)
	);

	bind boardtime_top boardtime_chk boardtime_chk_i (
		.dspclk(dspclk),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ready(ready),
		.start(start),
		.sync_tx(sync_tx)
	);

	// link looped back on the board
	assign sync_rx = sync_tx;

	initial dspclk = 1'b0;
	always #10 dspclk = ~dspclk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ LFSR_TAPS;
		end
		return n;
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int nbits, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// expected readback from the register rules
	function automatic logic [31:0] expected_read(input logic [7:0] adr);
		logic [31:0] v;
		v = '0;
		if (adr >= boardtime_pkg::REG_COEF_BASE
			&& adr < boardtime_pkg::REG_COEF_BASE + boardtime_pkg::COEF_N) begin
			v = coef_m[adr - boardtime_pkg::REG_COEF_BASE];
		end else begin
			case (adr)
				// strobe bit never reads back
				boardtime_pkg::REG_CTRL: v[2:0] = ctrl_m;
				boardtime_pkg::REG_CORR_L: v = corr_m[31:0];
				boardtime_pkg::REG_CORR_H: v = corr_m[63:32];
				boardtime_pkg::REG_TRIG_L: v = trig_m[31:0];
				boardtime_pkg::REG_TRIG_H: v = trig_m[63:32];
				default: v = '0;
			endcase
		end
		return v;
	endfunction

	task automatic expect_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// compare process, drains at the falling edge
	always @(negedge dspclk) begin : compare_proc
		logic [63:0] got;
		logic [63:0] exp;
		string name;
		while (got_q.size() > 0) begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			name = name_q.pop_front();
			if (got !== exp) begin
				$display("** Error: %s = %h, expected %h", name, got, exp);
				mismatch_count++;
			end
		end
	end

	// one classic cycle, held until ack
	task automatic wb_access(input logic we, input logic [7:0] adr,
		input logic [31:0] dat, output logic [31:0] rdat);
		int waited;
		waited = 0;
		rdat = '0;
		@(posedge dspclk);
		#2;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		@(posedge dspclk);
		#1;
		while (!wb_rsp.ack && waited < ACK_WAIT) begin
			@(posedge dspclk);
			#1;
			waited++;
		end
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
		end else begin
			$display("slave never acknowledged the access to address %0d", adr);
			other_errors++;
		end
		#1;
		wb_req = '0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		if (adr >= boardtime_pkg::REG_COEF_BASE) begin
			coef_m[adr - boardtime_pkg::REG_COEF_BASE] = dat;
		end
		case (adr)
			boardtime_pkg::REG_CTRL: ctrl_m = dat[2:0];
			boardtime_pkg::REG_CORR_L: corr_m[31:0] = dat;
			boardtime_pkg::REG_CORR_H: corr_m[63:32] = dat;
			boardtime_pkg::REG_TRIG_L: trig_m[31:0] = dat;
			boardtime_pkg::REG_TRIG_H: trig_m[63:32] = dat;
			default: ;
		endcase
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
		wb_access(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic read_check(input logic [7:0] adr);
		logic [31:0] d;
		wb_read(adr, d);
		expect_value($sformatf("reg[%0d]", adr), d, expected_read(adr));
	endtask

	// window read plus the flat port word
	task automatic coef_check(input int idx);
		read_check(8'(boardtime_pkg::REG_COEF_BASE + idx));
		expect_value($sformatf("coef[%0d]", idx), coef[idx], coef_m[idx]);
	endtask

	// low word first, high from the snapshot
	task automatic read64(input logic [7:0] adr_l, output logic [63:0] v);
		logic [31:0] lo;
		logic [31:0] hi;
		wb_read(adr_l, lo);
		wb_read(adr_l + 8'd1, hi);
		v = {hi, lo};
	endtask

	task automatic sysref_pulse();
		@(posedge dspclk);
		#2;
		sysref = 1'b1;
		repeat (2) @(posedge dspclk);
		#2;
		sysref = 1'b0;
		repeat (3) @(posedge dspclk);
		#1;
	endtask

	// frame takes about 70 cycles
	task automatic wait_rx_valid();
		logic [31:0] d;
		int polls;
		polls = 0;
		d = '0;
		repeat (8) @(posedge dspclk);
		while (!d[2] && polls < 60) begin
			wb_read(boardtime_pkg::REG_STATUS, d);
			polls++;
		end
		if (!d[2]) begin
			$display("rx_valid never came back after a link send");
			other_errors++;
		end
	endtask

	// one frame, stamps and payload
	task automatic link_send(output logic [63:0] txs);
		logic [63:0] rxs;
		logic [63:0] rxp;
		wb_write(boardtime_pkg::REG_LINK_GO, 32'h1);
		wait_rx_valid();
		read64(boardtime_pkg::REG_TXST_L, txs);
		read64(boardtime_pkg::REG_RXST_L, rxs);
		read64(boardtime_pkg::REG_RXPL_L, rxp);
		expect_value("rx_payload", rxp, txs);
		expect_value("rx_stamp - tx_stamp", rxs - txs, 64'(boardtime_pkg::LINK_LAT));
	endtask

	initial begin : main_seq
		logic [31:0] d;
		logic [63:0] r;
		logic [63:0] c1;
		logic [63:0] c2;
		logic [63:0] txs1;
		logic [63:0] txs2;
		int order [boardtime_pkg::COEF_N];
		int j;
		int tmp;
		int n;
		logic stayed;

		mismatch_count = 0;
		other_errors = 0;
		lfsr_state = 32'd87152;
		ctrl_m = '0;
		corr_m = '0;
		trig_m = '0;
		for (int i = 0; i < boardtime_pkg::COEF_N; i++) begin
			coef_m[i] = '0;
		end
		wb_req = '0;
		sysref = 1'b0;
		rst = 1'b1;
		repeat (8) @(posedge dspclk);
		#2;
		rst = 1'b0;

		// correction and trigger readback
		for (int a = boardtime_pkg::REG_CORR_L; a <= boardtime_pkg::REG_TRIG_H; a++) begin
			take_bits(32, r);
			wb_write(8'(a), r[31:0]);
		end
		for (int a = boardtime_pkg::REG_CORR_L; a <= boardtime_pkg::REG_TRIG_H; a++) begin
			read_check(8'(a));
		end
		wb_write(boardtime_pkg::REG_CTRL, 32'hA);
		read_check(boardtime_pkg::REG_CTRL);

		// coefficient bank, shuffled readback
		for (int i = 0; i < boardtime_pkg::COEF_N; i++) begin
			take_bits(32, r);
			wb_write(8'(boardtime_pkg::REG_COEF_BASE + i), r[31:0]);
			order[i] = i;
		end
		for (int i = boardtime_pkg::COEF_N - 1; i > 0; i--) begin
			take_bits(6, r);
			j = int'(r[5:0]) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < boardtime_pkg::COEF_N; i++) begin
			coef_check(order[i]);
		end

		// zero trigger while arming
		// only ready holds start off
		wb_write(boardtime_pkg::REG_CTRL, 32'h0);
		wb_write(boardtime_pkg::REG_CORR_L, 32'h0);
		wb_write(boardtime_pkg::REG_CORR_H, 32'h0);
		wb_write(boardtime_pkg::REG_TRIG_L, 32'h0);
		wb_write(boardtime_pkg::REG_TRIG_H, 32'h0);

		// timebase arming
		wb_write(boardtime_pkg::REG_CTRL, 32'h1);
		repeat (boardtime_pkg::SYSREF_EDGES - 1) begin
			sysref_pulse();
			expect_value("start", start, 64'd0);
		end
		wb_read(boardtime_pkg::REG_STATUS, d);
		expect_value("status ready", d[0], 64'd0);
		expect_value("status start", d[1], 64'd0);
		sysref_pulse();
		repeat (4) @(posedge dspclk);
		wb_read(boardtime_pkg::REG_STATUS, d);
		// zero trigger fires once the count runs
		expect_value("status ready", d[0], 64'd1);
		expect_value("status start", d[1], 64'd1);
		read64(boardtime_pkg::REG_CNT_L, c1);
		read64(boardtime_pkg::REG_CNT_L, c2);
		if (!(c2 > c1 && c2 - c1 >= 64'd2)) begin
			$display("count did not advance between reads, %h then %h", c1, c2);
			other_errors++;
		end

		// trigger out of reach of the raw count
		wb_write(boardtime_pkg::REG_TRIG_H, 32'h8000_0000);
		wb_read(boardtime_pkg::REG_STATUS, d);
		expect_value("status start", d[1], 64'd0);
		expect_value("start", start, 64'd0);
		// corr equal to trig, then select corrected count
		wb_write(boardtime_pkg::REG_CORR_H, 32'h8000_0000);
		wb_write(boardtime_pkg::REG_CTRL, 32'h3);
		n = 0;
		while (start !== 1'b1 && n < 10) begin
			@(posedge dspclk);
			#1;
			n++;
		end
		if (start !== 1'b1) begin
			$display("start did not rise after selecting the corrected count");
			other_errors++;
		end
		stayed = 1'b1;
		repeat (20) begin
			@(posedge dspclk);
			#1;
			if (start !== 1'b1) begin
				stayed = 1'b0;
			end
		end
		if (!stayed) begin
			$display("start dropped after it had risen");
			other_errors++;
		end

		// timestamp link over the loopback
		expect_value("sync_en", sync_en, 64'd0);
		wb_write(boardtime_pkg::REG_CTRL, 32'h7);
		// sync_en follows tx_en a cycle later
		@(posedge dspclk);
		#1;
		expect_value("sync_en", sync_en, 64'd1);
		link_send(txs1);
		link_send(txs2);
		if (!(txs2 > txs1)) begin
			$display("second tx stamp %h not above the first %h", txs2, txs1);
			other_errors++;
		end

		// dsp reset strobe, counted from the ack edge
		expect_value("dsp_reset", dsp_reset, 64'd0);
		wb_write(boardtime_pkg::REG_CTRL, 32'hF);
		n = 0;
		while (dsp_reset === 1'b1 && n < 20) begin
			n++;
			@(posedge dspclk);
			#1;
		end
		expect_value("dsp_reset cycles", 64'(n), 64'(boardtime_pkg::RESET_HOLD));
		read_check(boardtime_pkg::REG_CTRL);
		// state survives the dsp reset
		for (int a = boardtime_pkg::REG_CORR_L; a <= boardtime_pkg::REG_TRIG_H; a++) begin
			read_check(8'(a));
		end
		for (int i = 0; i < boardtime_pkg::COEF_N; i++) begin
			coef_check(i);
		end

		// let the compare process drain
		repeat (2) @(posedge dspclk);
		$display("checks done: %0d value mismatches, %0d other errors",
			mismatch_count, other_errors);
		if (mismatch_count + other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge dspclk);
		$display("watchdog expired after %0d cycles, sequence did not finish", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
src/boardtime_pkg.sv
src/wb_cfg_regs.sv
src/sysref_timebase.sv
src/coef_bank.sv
src/stamp_link.sv
src/boardtime_top.sv
tests/boardtime_chk.sv
tests/boardtime_tb.sv

// ==== Bender.yml ====
package:
  name: boardtime

sources:
  - src/boardtime_pkg.sv
  - src/wb_cfg_regs.sv
  - src/sysref_timebase.sv
  - src/coef_bank.sv
  - src/stamp_link.sv
  - src/boardtime_top.sv
  - target: test
    files:
      - tests/boardtime_chk.sv
      - tests/boardtime_tb.sv
